// ==== flist.f ====
verilog/vwMemPkg.sv
verilog/vwBusPkg.sv
verilog/addrGen.sv
verilog/bufferRam.sv
verilog/streamCapture.sv
verilog/burstReader.sv
verilog/vWriteTop.sv
tb/extBusSink.sv
tb/vWriteTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module vWriteTb -f flist.f -o vWriteSim

out=$(./obj_dir/vWriteSim)
echo "$out"

if echo "$out" | grep -qx "RESULT: PASS"; then
   exit 0
else
   exit 1
fi

// ==== tb/vWriteTb.sv ====
`timescale 1ns/1ps

module vWriteTb;
   import vwMemPkg::*;
   import vwBusPkg::*;

   localparam int NUM_ROWS = 7;

   typedef struct packed {
      logic     pingPong;
      periodT   iterations;
      periodT   period;
      halfAddrT start;
      halfAddrT incr;
      halfAddrT shift;
      logic     reverse;
      extAddrT  extAddr;
      burstLenT length;
   } rowT;

   typedef struct packed {
      extAddrT addr;
      dataT    data;
      logic    known;
      logic    last;
   } beatT;

   logic clk, rst, run, pingPong, done, reverse;
   logic busValid, busLast, busCredit;
   dataT inData, busData;
   periodT iterations, period;
   halfAddrT start, incr, shift;
   extAddrT extAddr, busAddr;
   burstLenT length;
   int beatCnt, peakOut;

   rowT rows [NUM_ROWS];
   dataT model [2**MEM_ADDR_W];
   logic known [2**MEM_ADDR_W];
   beatT expQ[$];
   beatT cur;
   int seed, errors, beatsChecked, totalBeats, cycles, limit;
   logic hReg;

   vWriteTop uut
   (
      .clk(clk), .rst(rst), .run(run), .pingPong(pingPong), .done(done),
      .inData(inData), .iterations(iterations), .period(period), .start(start),
      .incr(incr), .shift(shift), .reverse(reverse), .extAddr(extAddr),
      .length(length), .busValid(busValid), .busAddr(busAddr), .busData(busData),
      .busLast(busLast), .busCredit(busCredit)
   );

   extBusSink #(.SEED(32'hde64)) sink
   (
      .clk(clk), .rst(rst), .busValid(busValid), .busCredit(busCredit),
      .beatCnt(beatCnt), .peakOut(peakOut)
   );

   task automatic reportValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
   endtask

   task automatic reportFailure(input string msg);
      $display("** Error at %0t: %s", $time, msg);
      errors++;
   endtask

   function automatic rowT makeRow(input logic pp, input int it, input int per,
                                   input int st, input int inc, input int sh,
                                   input logic rev, input int ext, input int len);
      rowT r;
      r.pingPong = pp;
      r.iterations = periodT'(it);
      r.period = periodT'(per);
      r.start = halfAddrT'(st);
      r.incr = halfAddrT'(inc);
      r.shift = halfAddrT'(sh);
      r.reverse = rev;
      r.extAddr = extAddrT'(ext);
      r.length = burstLenT'(len);
      return r;
   endfunction

   // bit order mirrored within one half
   function automatic halfAddrT flipBits(input halfAddrT v);
      int res;
      res = 0;
      for (int i = 0; i < HALF_ADDR_W; i++)
         res = (res << 1) | ((int'(v) >> i) & 1);
      return halfAddrT'(res);
   endfunction

   task automatic applyRow(input rowT r);
      halfAddrT off;
      memAddrT a;
      logic capH, drH;
      dataT w;
      dataT words[$];
      beatT b;
      capH = r.pingPong ? hReg : 1'b0;
      drH = r.pingPong ? ~hReg : 1'b0;
      hReg = r.pingPong ? ~hReg : 1'b0;
      off = r.start;
      // capture into the model, then predict the drain
      for (int it = 0; it < int'(r.iterations); it++)
         for (int p = 0; p < int'(r.period); p++)
         begin
            w = $random(seed);
            words.push_back(w);
            a = {capH, r.reverse ? flipBits(off) : off};
            model[a] = w;
            known[a] = 1'b1;
            if (p == int'(r.period) - 1)
               off = off + r.incr + r.shift;
            else
               off = off + r.incr;
         end
      for (int i = 0; i < int'(r.length); i++)
      begin
         a = {drH, halfAddrT'(i)};
         b.addr = r.extAddr + extAddrT'(i);
         b.data = model[a];
         b.known = known[a];
         b.last = (i == int'(r.length) - 1);
         expQ.push_back(b);
      end
      totalBeats += int'(r.length);
      pingPong = r.pingPong;
      iterations = r.iterations;
      period = r.period;
      start = r.start;
      incr = r.incr;
      shift = r.shift;
      reverse = r.reverse;
      extAddr = r.extAddr;
      length = r.length;
      run = 1'b1;
      @(posedge clk);
      #1;
      run = 1'b0;
      if (done !== 1'b0)
         reportFailure("done did not fall after run");
      foreach (words[i])
      begin
         inData = words[i];
         @(posedge clk);
         #1;
      end
      while (done !== 1'b1)
      begin
         @(posedge clk);
         #1;
      end
      if (expQ.size() != 0)
         reportFailure($sformatf("done rose with %0d beats still missing", expQ.size()));
   endtask

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk)
   begin
      cycles = cycles + 1;
      if (cycles > limit)
      begin
         $display("timeout: run did not finish within %0d cycles", limit);
         $display("RESULT: FAIL");
         $finish;
      end
   end

   // beats checked mid-cycle against the prediction
   always @(negedge clk)
   begin
      if (!rst && busValid)
      begin
         if (expQ.size() == 0)
            reportFailure("bus beat arrived when none was expected");
         else
         begin
            cur = expQ.pop_front();
            if (busAddr !== cur.addr)
               reportValue("busAddr", 32'(busAddr), 32'(cur.addr));
            if (cur.known && (busData !== cur.data))
               reportValue("busData", busData, cur.data);
            if (busLast !== cur.last)
               reportValue("busLast", 32'(busLast), 32'(cur.last));
            beatsChecked++;
         end
      end
   end

   initial
   begin
      seed = 32'hde64;
      errors = 0;
      beatsChecked = 0;
      totalBeats = 0;
      cycles = 0;
      hReg = 1'b0;
      rst = 1'b1;
      run = 1'b0;
      pingPong = 1'b0;
      inData = '0;
      iterations = '0;
      period = '0;
      start = '0;
      incr = '0;
      shift = '0;
      reverse = 1'b0;
      extAddr = '0;
      length = '0;
      for (int i = 0; i < 2**MEM_ADDR_W; i++)
      begin
         model[i] = '0;
         known[i] = 1'b0;
      end
      // mode, iter, period, start, incr, shift, reverse, extAddr, length
      rows[0] = makeRow(1'b0, 4, 16, 0, 1, 0, 1'b0, 16'h1000, 64);
      rows[1] = makeRow(1'b0, 4, 4, 0, 2, 1, 1'b0, 16'h2000, 40);
      rows[2] = makeRow(1'b0, 2, 8, 0, 1, 0, 1'b1, 16'h3000, 128);
      rows[3] = makeRow(1'b1, 2, 8, 5, 3, 2, 1'b0, 16'h4000, 32);
      rows[4] = makeRow(1'b1, 1, 32, 0, 1, 0, 1'b0, 16'h5000, 32);
      rows[5] = makeRow(1'b1, 3, 8, 100, 5, 7, 1'b1, 16'hfff0, 32);
      rows[6] = makeRow(1'b0, 2, 5, 10, 1, 0, 1'b0, 16'h6000, 20);
      limit = 0;
      for (int i = 0; i < NUM_ROWS; i++)
         limit += int'(rows[i].iterations) * int'(rows[i].period) +
                  8 * int'(rows[i].length) + 50;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
      if (done !== 1'b1)
         reportValue("done", 32'(done), 32'd1);
      if (busValid !== 1'b0)
         reportValue("busValid", 32'(busValid), 32'd0);
      for (int i = 0; i < NUM_ROWS; i++)
         applyRow(rows[i]);
      if (beatCnt != totalBeats)
         reportFailure($sformatf("sink saw %0d beats, %0d were sent", beatCnt, totalBeats));
      if (peakOut > BUS_CREDITS)
         reportFailure($sformatf("%0d beats were outstanding at once", peakOut));
      $display("errors: %0d, beats checked: %0d of %0d, peak outstanding: %0d",
               errors, beatsChecked, totalBeats, peakOut);
      if (errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

// ==== tb/extBusSink.sv ====
`timescale 1ns/1ps

module extBusSink
#(
   parameter int SEED = 32'hde64
)
(
   input  logic clk,
   input  logic rst,
   input  logic busValid,
   output logic busCredit,
   output int   beatCnt,
   output int   peakOut
);
   int seed;
   int cycle;
   int creditCnt;
   int dueQ[$];

   initial
   begin
      seed = SEED;
      cycle = 0;
      creditCnt = 0;
      beatCnt = 0;
      peakOut = 0;
      busCredit = 1'b0;
   end

   // beats and credits counted mid-cycle
   always @(negedge clk)
   begin
      if (!rst && busValid)
      begin
         beatCnt = beatCnt + 1;
         dueQ.push_back(cycle + 1 + int'($unsigned($random(seed)) % 6));
         if (beatCnt - creditCnt > peakOut)
            peakOut = beatCnt - creditCnt;
      end
      if (busCredit)
         creditCnt = creditCnt + 1;
   end

   // one credit per cycle at most, oldest beat first
   always @(posedge clk)
   begin
      cycle = cycle + 1;
      #1;
      busCredit = 1'b0;
      if (dueQ.size() > 0)
      begin
         if (dueQ[0] <= cycle)
         begin
            busCredit = 1'b1;
            void'(dueQ.pop_front());
         end
      end
   end

endmodule

// ==== verilog/vWriteTop.sv ====
`timescale 1ns/1ps

module vWriteTop
(
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  logic               pingPong,
   output logic               done,
   input  vwMemPkg::dataT     inData,
   input  vwMemPkg::periodT   iterations,
   input  vwMemPkg::periodT   period,
   input  vwMemPkg::halfAddrT start,
   input  vwMemPkg::halfAddrT incr,
   input  vwMemPkg::halfAddrT shift,
   input  logic               reverse,
   input  vwBusPkg::extAddrT  extAddr,
   input  vwBusPkg::burstLenT length,
   output logic               busValid,
   output vwBusPkg::extAddrT  busAddr,
   output vwMemPkg::dataT     busData,
   output logic               busLast,
   input  logic               busCredit
);
   import vwMemPkg::*;

   logic    halfReg;
   logic    capHalf;
   logic    drainHalf;
   logic    drainGo;
   logic    captureDone;
   logic    drainDone;
   logic    capFin;
   logic    drainFin;
   logic    wrEn;
   memAddrT wrAddr;
   dataT    wrData;
   logic    rdEn;
   memAddrT rdAddr;
   dataT    rdData;

   // halves are sampled by both sides on the run pulse, before the toggle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         halfReg <= 1'b0;
      else if (run)
         halfReg <= pingPong ? ~halfReg : 1'b0;
   end

   assign capHalf = pingPong ? halfReg : 1'b0;
   assign drainHalf = pingPong ? ~halfReg : 1'b0;

   // ping-pong drains the previous half right away
   assign drainGo = pingPong ? run : captureDone;

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         capFin <= 1'b1;
         drainFin <= 1'b1;
      end
      else if (run)
      begin
         capFin <= 1'b0;
         // an empty drain finishes on the run pulse itself
         drainFin <= drainDone;
      end
      else
      begin
         if (captureDone)
            capFin <= 1'b1;
         if (drainDone)
            drainFin <= 1'b1;
      end
   end

   assign done = capFin && drainFin;

   streamCapture capture
   (
      .clk         (clk),
      .rst         (rst),
      .run         (run),
      .capHalf     (capHalf),
      .iterations  (iterations),
      .period      (period),
      .start       (start),
      .incr        (incr),
      .shift       (shift),
      .reverse     (reverse),
      .inData      (inData),
      .wrEn        (wrEn),
      .wrAddr      (wrAddr),
      .wrData      (wrData),
      .captureDone (captureDone)
   );

   bufferRam buffer
   (
      .clk    (clk),
      .wrEn   (wrEn),
      .wrAddr (wrAddr),
      .wrData (wrData),
      .rdEn   (rdEn),
      .rdAddr (rdAddr),
      .rdData (rdData)
   );

   burstReader reader
   (
      .clk       (clk),
      .rst       (rst),
      .drainGo   (drainGo),
      .drainHalf (drainHalf),
      .extAddr   (extAddr),
      .length    (length),
      .rdData    (rdData),
      .busCredit (busCredit),
      .rdEn      (rdEn),
      .rdAddr    (rdAddr),
      .busValid  (busValid),
      .busAddr   (busAddr),
      .busData   (busData),
      .busLast   (busLast),
      .drainDone (drainDone)
   );

endmodule

// ==== verilog/burstReader.sv ====
`timescale 1ns/1ps

module burstReader
(
   input  logic              clk,
   input  logic              rst,
   input  logic              drainGo,
   input  logic              drainHalf,
   input  vwBusPkg::extAddrT extAddr,
   input  vwBusPkg::burstLenT length,
   input  vwMemPkg::dataT    rdData,
   input  logic              busCredit,
   output logic              rdEn,
   output vwMemPkg::memAddrT rdAddr,
   output logic              busValid,
   output vwBusPkg::extAddrT busAddr,
   output vwMemPkg::dataT    busData,
   output logic              busLast,
   output logic              drainDone
);
   import vwMemPkg::*;
   import vwBusPkg::*;

   typedef enum logic [1:0] {IDLE, WAIT, DRAIN} rdStateT;

   rdStateT  state;
   creditT   credits;
   burstLenT rdCnt;
   burstLenT lenLast;
   logic     half;
   logic     lastRead;

   assign lenLast = length - 1'b1;
   assign lastRead = (rdCnt == lenLast);

   // a read needs a credit for its own beat and for the beat now on the bus
   assign rdEn = (state == DRAIN) && (credits > creditT'(busValid));
   assign rdAddr = {half, rdCnt[HALF_ADDR_W-1:0]};
   assign busData = rdData;

   assign drainDone = ((state == WAIT) && busLast) ||
                      ((state == IDLE) && drainGo && (length == '0));

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= IDLE;
         credits <= creditT'(BUS_CREDITS);
         rdCnt <= '0;
         half <= 1'b0;
         busValid <= 1'b0;
         busLast <= 1'b0;
      end
      else
      begin
         busValid <= rdEn;
         busLast <= rdEn && lastRead;
         case ({busValid, busCredit})
            2'b10: credits <= credits - 1'b1;
            2'b01: credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
         case (state)
            IDLE:
            begin
               if (drainGo && (length != '0))
               begin
                  half <= drainHalf;
                  rdCnt <= '0;
                  state <= DRAIN;
               end
            end
            DRAIN:
            begin
               if (rdEn)
               begin
                  rdCnt <= rdCnt + 1'b1;
                  if (lastRead)
                     state <= WAIT;
               end
            end
            WAIT:
            begin
               // last beat leaves the cycle after its read
               if (busLast)
                  state <= IDLE;
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (rdEn)
         busAddr <= extAddr + extAddrT'(rdCnt);
   end

endmodule

// ==== verilog/streamCapture.sv ====
`timescale 1ns/1ps

module streamCapture
(
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  logic               capHalf,
   input  vwMemPkg::periodT   iterations,
   input  vwMemPkg::periodT   period,
   input  vwMemPkg::halfAddrT start,
   input  vwMemPkg::halfAddrT incr,
   input  vwMemPkg::halfAddrT shift,
   input  logic               reverse,
   input  vwMemPkg::dataT     inData,
   output logic               wrEn,
   output vwMemPkg::memAddrT  wrAddr,
   output vwMemPkg::dataT     wrData,
   output logic               captureDone
);
   import vwMemPkg::*;

   memAddrT genStart;
   memAddrT genAddr;
   logic    genValid;

   function automatic halfAddrT reverseBits(input halfAddrT word);
      halfAddrT res;
      for (int i = 0; i < HALF_ADDR_W; i++)
         res[i] = word[HALF_ADDR_W-1-i];
      return res;
   endfunction

   assign genStart = {capHalf, start};

   addrGen gen
   (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .start      (genStart),
      .iterations (iterations),
      .period     (period),
      .incr       (incr),
      .shift      (shift),
      .valid      (genValid),
      .addr       (genAddr),
      .done       (captureDone)
   );

   // reversal stays inside the half
   assign wrAddr = reverse ?
      {genAddr[MEM_ADDR_W-1], reverseBits(genAddr[HALF_ADDR_W-1:0])} : genAddr;

   assign wrEn = genValid;
   assign wrData = inData;

endmodule

// ==== verilog/bufferRam.sv ====
`timescale 1ns/1ps

module bufferRam
(
   input  logic              clk,
   input  logic              wrEn,
   input  vwMemPkg::memAddrT wrAddr,
   input  vwMemPkg::dataT    wrData,
   input  logic              rdEn,
   input  vwMemPkg::memAddrT rdAddr,
   output vwMemPkg::dataT    rdData
);
   import vwMemPkg::*;

   dataT mem [2**MEM_ADDR_W];

   always_ff @(posedge clk)
   begin
      if (wrEn)
         mem[wrAddr] <= wrData;
   end

   // registered read, data one cycle after rdEn
   always_ff @(posedge clk)
   begin
      if (rdEn)
         rdData <= mem[rdAddr];
   end

endmodule

// ==== verilog/addrGen.sv ====
`timescale 1ns/1ps

module addrGen
(
   input  logic               clk,
   input  logic               rst,
   input  logic               run,
   input  vwMemPkg::memAddrT  start,
   input  vwMemPkg::periodT   iterations,
   input  vwMemPkg::periodT   period,
   input  vwMemPkg::halfAddrT incr,
   input  vwMemPkg::halfAddrT shift,
   output logic               valid,
   output vwMemPkg::memAddrT  addr,
   output logic               done
);
   import vwMemPkg::*;

   typedef enum logic {IDLE, RUN} genStateT;

   genStateT state;
   periodT   perCnt;
   periodT   iterCnt;
   periodT   perLast;
   periodT   iterLast;
   halfAddrT offset;
   logic     half;
   logic     periodEnd;
   logic     lastAddr;

   assign perLast = period - 1'b1;
   assign iterLast = iterations - 1'b1;
   assign periodEnd = (perCnt == perLast);
   assign lastAddr = periodEnd && (iterCnt == iterLast);

   assign valid = (state == RUN);
   // half bit is fixed for the whole run
   assign addr = {half, offset};

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= IDLE;
         done <= 1'b0;
         perCnt <= '0;
         iterCnt <= '0;
         offset <= '0;
         half <= 1'b0;
      end
      else
      begin
         done <= 1'b0;
         case (state)
            IDLE:
            begin
               if (run)
               begin
                  perCnt <= '0;
                  iterCnt <= '0;
                  offset <= start[HALF_ADDR_W-1:0];
                  half <= start[MEM_ADDR_W-1];
                  // empty pattern finishes at once
                  if ((iterations == '0) || (period == '0))
                     done <= 1'b1;
                  else
                     state <= RUN;
               end
            end
            RUN:
            begin
               if (periodEnd)
               begin
                  perCnt <= '0;
                  iterCnt <= iterCnt + 1'b1;
                  // shift on top of the step at a period boundary
                  offset <= offset + incr + shift;
               end
               else
               begin
                  perCnt <= perCnt + 1'b1;
                  offset <= offset + incr;
               end
               if (lastAddr)
               begin
                  state <= IDLE;
                  done <= 1'b1;
               end
            end
            default:
            begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

// ==== verilog/vwBusPkg.sv ====
package vwBusPkg;

   // external word address
   localparam int EXT_ADDR_W = 16;

   // credits granted at reset, also the bound on unreturned beats
   localparam int BUS_CREDITS = 4;
   localparam int CREDIT_W = $clog2(BUS_CREDITS + 1);

   localparam int BURST_LEN_W = 8;

   typedef logic [EXT_ADDR_W-1:0] extAddrT;

   typedef logic [CREDIT_W-1:0] creditT;

   typedef logic [BURST_LEN_W-1:0] burstLenT;

endpackage

// ==== verilog/vwMemPkg.sv ====
package vwMemPkg;

   // buffer of 256 words, top address bit picks the half
   localparam int MEM_ADDR_W = 8;
   localparam int HALF_ADDR_W = MEM_ADDR_W - 1;

   // iteration and period counters
   localparam int PERIOD_W = 8;

   // stream and buffer word
   localparam int DATA_W = 32;

   typedef logic [MEM_ADDR_W-1:0] memAddrT;

   // start, increment, shift and length fields live inside one half
   typedef logic [HALF_ADDR_W-1:0] halfAddrT;

   typedef logic [PERIOD_W-1:0] periodT;

   typedef logic [DATA_W-1:0] dataT;

endpackage
